// ==== src/rv_pkg.sv ====
package rv_pkg;

    // datapath and memory widths
    localparam int XLEN       = 32;
    localparam int REG_ADDR_W = 5;
    localparam int IMEM_AW    = 6;  // 64 words
    localparam int DMEM_AW    = 6;

    typedef logic [XLEN-1:0]       word_t;
    typedef logic [REG_ADDR_W-1:0] reg_addr_t;
    typedef logic [3:0]            alu_ctrl_t;
    typedef logic [1:0]            result_src_t;
    typedef logic [1:0]            fwd_sel_t;
    typedef logic [IMEM_AW-1:0]    imem_addr_t;

    // major opcodes, instr[6:0]
    localparam logic [6:0] OP_R   = 7'b0110011;
    localparam logic [6:0] OP_I   = 7'b0010011;
    localparam logic [6:0] OP_LW  = 7'b0000011;
    localparam logic [6:0] OP_SW  = 7'b0100011;
    localparam logic [6:0] OP_B   = 7'b1100011;
    localparam logic [6:0] OP_JAL = 7'b1101111;
    localparam logic [6:0] OP_LUI = 7'b0110111;

    // funct3 of the supported operations
    localparam logic [2:0] FUNCT3_ADD = 3'b000;  // also sub, beq
    localparam logic [2:0] FUNCT3_BNE = 3'b001;
    localparam logic [2:0] FUNCT3_SLT = 3'b010;
    localparam logic [2:0] FUNCT3_OR  = 3'b110;
    localparam logic [2:0] FUNCT3_AND = 3'b111;

    // alu operations
    localparam alu_ctrl_t ALU_ADD   = 4'd0;
    localparam alu_ctrl_t ALU_SUB   = 4'd1;
    localparam alu_ctrl_t ALU_AND   = 4'd2;
    localparam alu_ctrl_t ALU_OR    = 4'd3;
    localparam alu_ctrl_t ALU_SLT   = 4'd4;
    localparam alu_ctrl_t ALU_PASSB = 4'd5;

    // writeback source
    localparam result_src_t RES_ALU = 2'b00;
    localparam result_src_t RES_MEM = 2'b01;
    localparam result_src_t RES_PC4 = 2'b10;

    // execute operand source, 2'b11 is never used
    localparam fwd_sel_t FWD_NONE = 2'b00;
    localparam fwd_sel_t FWD_W    = 2'b01;
    localparam fwd_sel_t FWD_M    = 2'b10;

endpackage

// ==== src/imem.sv ====
`timescale 1ns/1ps

module imem (
    input  logic               clk_i,
    input  rv_pkg::imem_addr_t addr_i,
    output rv_pkg::word_t      rd_o,
    input  logic               we_i,
    input  rv_pkg::imem_addr_t waddr_i,
    input  rv_pkg::word_t      wdata_i
);
    import rv_pkg::*;

    word_t mem [2**IMEM_AW];

    assign rd_o = mem[addr_i];  // fetch is combinational

    // program load port
    always_ff @(posedge clk_i) begin
        if (we_i) begin
            mem[waddr_i] <= wdata_i;
        end
    end

endmodule

// ==== src/reg_file.sv ====
`timescale 1ns/1ps

module reg_file (
    input  logic              clk_i,
    input  logic              rst_n_i,
    input  rv_pkg::reg_addr_t ra1_i,
    input  rv_pkg::reg_addr_t ra2_i,
    input  rv_pkg::reg_addr_t wa_i,
    input  logic              we_i,
    input  rv_pkg::word_t     wd_i,
    output rv_pkg::word_t     rd1_o,
    output rv_pkg::word_t     rd2_o,
    output rv_pkg::word_t     a0_o
);
    import rv_pkg::*;

    word_t regs [32];  // x0 entry is never written
    logic  wr_en;

    assign wr_en = we_i && (wa_i != '0);

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (wr_en) begin
            regs[wa_i] <= wd_i;
        end
    end

    // write-through, so decode sees the value retiring this cycle
    assign rd1_o = (wr_en && wa_i == ra1_i) ? wd_i : regs[ra1_i];
    assign rd2_o = (wr_en && wa_i == ra2_i) ? wd_i : regs[ra2_i];

    assign a0_o = regs[10];

    assert property (@(posedge clk_i) disable iff (!rst_n_i)
        !((ra1_i == '0 && rd1_o != '0) || (ra2_i == '0 && rd2_o != '0)));

endmodule

// ==== src/control_decoder.sv ====
`timescale 1ns/1ps

module control_decoder (
    input  rv_pkg::word_t       instr_i,
    output logic                reg_write_o,
    output logic                mem_write_o,
    output logic                alu_src_o,
    output logic                branch_o,
    output logic                jump_o,
    output rv_pkg::result_src_t result_src_o,
    output rv_pkg::alu_ctrl_t   alu_ctrl_o,
    output rv_pkg::word_t       imm_o
);
    import rv_pkg::*;

    logic [6:0] opcode;
    logic [2:0] funct3;
    logic       funct7_b5;
    word_t      imm_i_fmt, imm_s_fmt, imm_b_fmt, imm_j_fmt, imm_u_fmt;

    assign opcode    = instr_i[6:0];
    assign funct3    = instr_i[14:12];
    assign funct7_b5 = instr_i[30];

    // sign-extended immediates
    assign imm_i_fmt = {{20{instr_i[31]}}, instr_i[31:20]};
    assign imm_s_fmt = {{20{instr_i[31]}}, instr_i[31:25], instr_i[11:7]};
    assign imm_b_fmt = {{19{instr_i[31]}}, instr_i[31], instr_i[7],
                        instr_i[30:25], instr_i[11:8], 1'b0};
    assign imm_j_fmt = {{11{instr_i[31]}}, instr_i[31], instr_i[19:12],
                        instr_i[20], instr_i[30:21], 1'b0};
    assign imm_u_fmt = {instr_i[31:12], 12'b0};

    // r-type and i-type share this, only r-type can subtract
    function automatic alu_ctrl_t arith_ctrl(input logic [2:0] f3, input logic sub);
        alu_ctrl_t ctrl;
        case (f3)
            FUNCT3_ADD: ctrl = sub ? ALU_SUB : ALU_ADD;
            FUNCT3_SLT: ctrl = ALU_SLT;
            FUNCT3_OR:  ctrl = ALU_OR;
            FUNCT3_AND: ctrl = ALU_AND;
            default:    ctrl = ALU_ADD;
        endcase
        return ctrl;
    endfunction

    always_comb begin
        // bubble unless the opcode is known
        reg_write_o  = 1'b0;
        mem_write_o  = 1'b0;
        alu_src_o    = 1'b0;
        branch_o     = 1'b0;
        jump_o       = 1'b0;
        result_src_o = RES_ALU;
        alu_ctrl_o   = ALU_ADD;
        imm_o        = '0;

        case (opcode)
            OP_R: begin
                reg_write_o = 1'b1;
                alu_ctrl_o  = arith_ctrl(funct3, funct7_b5);
            end
            OP_I: begin
                reg_write_o = 1'b1;
                alu_src_o   = 1'b1;
                alu_ctrl_o  = arith_ctrl(funct3, 1'b0);
                imm_o       = imm_i_fmt;
            end
            OP_LW: begin
                reg_write_o  = 1'b1;
                alu_src_o    = 1'b1;
                result_src_o = RES_MEM;
                imm_o        = imm_i_fmt;
            end
            OP_SW: begin
                mem_write_o = 1'b1;
                alu_src_o   = 1'b1;
                imm_o       = imm_s_fmt;
            end
            OP_B: begin
                branch_o   = 1'b1;  // compare uses the alu eq flag
                alu_ctrl_o = ALU_SUB;
                imm_o      = imm_b_fmt;
            end
            OP_JAL: begin
                reg_write_o  = 1'b1;
                jump_o       = 1'b1;
                result_src_o = RES_PC4;
                imm_o        = imm_j_fmt;
            end
            OP_LUI: begin
                reg_write_o = 1'b1;
                alu_src_o   = 1'b1;
                alu_ctrl_o  = ALU_PASSB;
                imm_o       = imm_u_fmt;
            end
            default: begin
                imm_o = '0;
            end
        endcase
    end

endmodule

// ==== src/alu.sv ====
`timescale 1ns/1ps

module alu (
    input  rv_pkg::word_t     a_i,
    input  rv_pkg::word_t     b_i,
    input  rv_pkg::alu_ctrl_t ctrl_i,
    output rv_pkg::word_t     y_o,
    output logic              eq_o
);
    import rv_pkg::*;

    always_comb begin
        case (ctrl_i)
            ALU_ADD:   y_o = a_i + b_i;
            ALU_SUB:   y_o = a_i - b_i;
            ALU_AND:   y_o = a_i & b_i;
            ALU_OR:    y_o = a_i | b_i;
            ALU_SLT:   y_o = {{(XLEN-1){1'b0}}, $signed(a_i) < $signed(b_i)};
            ALU_PASSB: y_o = b_i;  // lui
            default:   y_o = '0;
        endcase
    end

    // branch compare, independent of the operation
    assign eq_o = (a_i == b_i);

endmodule

// ==== src/hazard_unit.sv ====
`timescale 1ns/1ps

module hazard_unit (
    input  rv_pkg::reg_addr_t rs1_d_i,
    input  rv_pkg::reg_addr_t rs2_d_i,
    input  rv_pkg::reg_addr_t rs1_e_i,
    input  rv_pkg::reg_addr_t rs2_e_i,
    input  rv_pkg::reg_addr_t rd_e_i,
    input  rv_pkg::reg_addr_t rd_m_i,
    input  rv_pkg::reg_addr_t rd_w_i,
    input  logic              reg_write_m_i,
    input  logic              reg_write_w_i,
    input  logic              load_e_i,
    input  logic              redirect_e_i,
    output rv_pkg::fwd_sel_t  fwd_a_o,
    output rv_pkg::fwd_sel_t  fwd_b_o,
    output logic              stall_f_o,
    output logic              stall_d_o,
    output logic              flush_d_o,
    output logic              flush_e_o
);
    import rv_pkg::*;

    logic load_use;

    // memory stage holds the newer value, so it wins
    function automatic fwd_sel_t fwd_for(input reg_addr_t rs, input reg_addr_t rd_m,
                                         input logic we_m, input reg_addr_t rd_w,
                                         input logic we_w);
        fwd_sel_t sel;
        if (rs == '0) begin
            sel = FWD_NONE;
        end else if (we_m && rs == rd_m) begin
            sel = FWD_M;
        end else if (we_w && rs == rd_w) begin
            sel = FWD_W;
        end else begin
            sel = FWD_NONE;
        end
        return sel;
    endfunction

    assign fwd_a_o = fwd_for(rs1_e_i, rd_m_i, reg_write_m_i, rd_w_i, reg_write_w_i);
    assign fwd_b_o = fwd_for(rs2_e_i, rd_m_i, reg_write_m_i, rd_w_i, reg_write_w_i);

    // load data is not there until after the memory stage
    assign load_use = load_e_i && (rd_e_i != '0) &&
                      (rs1_d_i == rd_e_i || rs2_d_i == rd_e_i);

    assign stall_f_o = load_use;
    assign stall_d_o = load_use;
    assign flush_d_o = redirect_e_i;
    assign flush_e_o = load_use | redirect_e_i;  // bubble behind the load

    // a stalled pc would drop the redirect target
    always_comb begin
        assert (!(load_use && redirect_e_i))
            else $error("hazard_unit: load-use stall during a redirect");
    end

endmodule

// ==== src/dmem.sv ====
`timescale 1ns/1ps

module dmem (
    input  logic          clk_i,
    input  logic          we_i,
    input  rv_pkg::word_t addr_i,
    input  rv_pkg::word_t wd_i,
    output rv_pkg::word_t rd_o
);
    import rv_pkg::*;

    word_t              mem [2**DMEM_AW];
    logic [DMEM_AW-1:0] word_addr;

    assign word_addr = addr_i[DMEM_AW+1:2];  // byte address to word index
    assign rd_o      = mem[word_addr];

    always_ff @(posedge clk_i) begin
        if (we_i) begin
            mem[word_addr] <= wd_i;
        end
    end

    // only word stores exist, so the program must keep them aligned
    assert property (@(posedge clk_i) we_i |-> (addr_i[1:0] == 2'b00));

endmodule

// ==== src/rv_core_top.sv ====
`timescale 1ns/1ps

module rv_core_top (
    input  logic               clk_i,
    input  logic               rst_n_i,
    input  logic               imem_we_i,
    input  rv_pkg::imem_addr_t imem_addr_i,
    input  rv_pkg::word_t      imem_data_i,
    output rv_pkg::word_t      a0_o
);
    import rv_pkg::*;

    // fetch
    word_t pc_f, pc_plus4_f, pc_next, instr_f;

    // decode
    word_t       instr_d, pc_d, pc_plus4_d, rd1_d, rd2_d, imm_d;
    reg_addr_t   rs1_d, rs2_d, rd_d;
    logic        reg_write_d, mem_write_d, alu_src_d, branch_d, jump_d;
    result_src_t result_src_d;
    alu_ctrl_t   alu_ctrl_d;

    // execute
    logic        reg_write_e, mem_write_e, alu_src_e, branch_e, jump_e;
    result_src_t result_src_e;
    alu_ctrl_t   alu_ctrl_e;
    reg_addr_t   rs1_e, rs2_e, rd_e;
    logic [2:0]  funct3_e;
    word_t       rd1_e, rd2_e, imm_e, pc_e, pc_plus4_e;
    word_t       src_a_e, fwd_b_val_e, src_b_e, alu_y_e, pc_target_e;
    logic        eq_e, redirect_e;
    fwd_sel_t    fwd_a_e, fwd_b_e;

    // memory and writeback
    logic        reg_write_m, mem_write_m, reg_write_w;
    result_src_t result_src_m, result_src_w;
    reg_addr_t   rd_m, rd_w;
    word_t       alu_m, wdata_m, rdata_m, pc_plus4_m;
    word_t       alu_w, rdata_w, pc_plus4_w, result_w;

    logic stall_f, stall_d, flush_d, flush_e;

    assign pc_plus4_f = pc_f + 32'd4;
    assign pc_next    = redirect_e ? pc_target_e : pc_plus4_f;

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            pc_f <= '0;
        end else if (!stall_f) begin
            pc_f <= pc_next;
        end
    end

    imem imem_i (
        .clk_i   (clk_i),
        .addr_i  (pc_f[IMEM_AW+1:2]),
        .rd_o    (instr_f),
        .we_i    (imem_we_i),
        .waddr_i (imem_addr_i),
        .wdata_i (imem_data_i)
    );

    // fetch/decode, an all-zero word decodes as a bubble
    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            instr_d <= '0;
        end else if (flush_d) begin
            instr_d <= '0;
        end else if (!stall_d) begin
            instr_d <= instr_f;
        end
    end

    always_ff @(posedge clk_i) begin
        if (!stall_d) begin
            pc_d       <= pc_f;
            pc_plus4_d <= pc_plus4_f;
        end
    end

    assign rs1_d = instr_d[19:15];
    assign rs2_d = instr_d[24:20];
    assign rd_d  = instr_d[11:7];

    reg_file reg_file_i (
        .clk_i   (clk_i),
        .rst_n_i (rst_n_i),
        .ra1_i   (rs1_d),
        .ra2_i   (rs2_d),
        .wa_i    (rd_w),
        .we_i    (reg_write_w),
        .wd_i    (result_w),
        .rd1_o   (rd1_d),
        .rd2_o   (rd2_d),
        .a0_o    (a0_o)
    );

    control_decoder control_decoder_i (
        .instr_i      (instr_d),
        .reg_write_o  (reg_write_d),
        .mem_write_o  (mem_write_d),
        .alu_src_o    (alu_src_d),
        .branch_o     (branch_d),
        .jump_o       (jump_d),
        .result_src_o (result_src_d),
        .alu_ctrl_o   (alu_ctrl_d),
        .imm_o        (imm_d)
    );

    // decode/execute control, cleared on load-use stall or redirect
    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            reg_write_e  <= 1'b0;
            mem_write_e  <= 1'b0;
            branch_e     <= 1'b0;
            jump_e       <= 1'b0;
            result_src_e <= RES_ALU;
            rs1_e        <= '0;
            rs2_e        <= '0;
            rd_e         <= '0;
        end else begin
            reg_write_e  <= flush_e ? 1'b0 : reg_write_d;
            mem_write_e  <= flush_e ? 1'b0 : mem_write_d;
            branch_e     <= flush_e ? 1'b0 : branch_d;
            jump_e       <= flush_e ? 1'b0 : jump_d;
            result_src_e <= flush_e ? RES_ALU : result_src_d;
            rs1_e        <= flush_e ? '0 : rs1_d;
            rs2_e        <= flush_e ? '0 : rs2_d;
            rd_e         <= flush_e ? '0 : rd_d;
        end
    end

    always_ff @(posedge clk_i) begin
        alu_src_e  <= alu_src_d;
        alu_ctrl_e <= alu_ctrl_d;
        funct3_e   <= instr_d[14:12];
        rd1_e      <= rd1_d;
        rd2_e      <= rd2_d;
        imm_e      <= imm_d;
        pc_e       <= pc_d;
        pc_plus4_e <= pc_plus4_d;
    end

    function automatic word_t fwd_mux(input fwd_sel_t sel, input word_t reg_val,
                                      input word_t mem_val, input word_t wb_val);
        word_t val;
        case (sel)
            FWD_M:   val = mem_val;
            FWD_W:   val = wb_val;
            default: val = reg_val;
        endcase
        return val;
    endfunction

    assign src_a_e     = fwd_mux(fwd_a_e, rd1_e, alu_m, result_w);
    assign fwd_b_val_e = fwd_mux(fwd_b_e, rd2_e, alu_m, result_w);
    assign src_b_e     = alu_src_e ? imm_e : fwd_b_val_e;

    alu alu_i (
        .a_i    (src_a_e),
        .b_i    (src_b_e),
        .ctrl_i (alu_ctrl_e),
        .y_o    (alu_y_e),
        .eq_o   (eq_e)
    );

    // bne inverts the equal flag
    assign redirect_e  = jump_e | (branch_e & (eq_e ^ (funct3_e == FUNCT3_BNE)));
    assign pc_target_e = pc_e + imm_e;

    // execute/memory
    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            reg_write_m  <= 1'b0;
            mem_write_m  <= 1'b0;
            result_src_m <= RES_ALU;
            rd_m         <= '0;
        end else begin
            reg_write_m  <= reg_write_e;
            mem_write_m  <= mem_write_e;
            result_src_m <= result_src_e;
            rd_m         <= rd_e;
        end
    end

    always_ff @(posedge clk_i) begin
        alu_m      <= alu_y_e;
        wdata_m    <= fwd_b_val_e;  // store data sees forwarding too
        pc_plus4_m <= pc_plus4_e;
    end

    dmem dmem_i (
        .clk_i  (clk_i),
        .we_i   (mem_write_m),
        .addr_i (alu_m),
        .wd_i   (wdata_m),
        .rd_o   (rdata_m)
    );

    // memory/writeback
    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            reg_write_w  <= 1'b0;
            result_src_w <= RES_ALU;
            rd_w         <= '0;
        end else begin
            reg_write_w  <= reg_write_m;
            result_src_w <= result_src_m;
            rd_w         <= rd_m;
        end
    end

    always_ff @(posedge clk_i) begin
        alu_w      <= alu_m;
        rdata_w    <= rdata_m;
        pc_plus4_w <= pc_plus4_m;
    end

    always_comb begin
        case (result_src_w)
            RES_MEM: result_w = rdata_w;
            RES_PC4: result_w = pc_plus4_w;  // jal link
            default: result_w = alu_w;
        endcase
    end

    hazard_unit hazard_unit_i (
        .rs1_d_i       (rs1_d),
        .rs2_d_i       (rs2_d),
        .rs1_e_i       (rs1_e),
        .rs2_e_i       (rs2_e),
        .rd_e_i        (rd_e),
        .rd_m_i        (rd_m),
        .rd_w_i        (rd_w),
        .reg_write_m_i (reg_write_m),
        .reg_write_w_i (reg_write_w),
        .load_e_i      (result_src_e == RES_MEM),
        .redirect_e_i  (redirect_e),
        .fwd_a_o       (fwd_a_e),
        .fwd_b_o       (fwd_b_e),
        .stall_f_o     (stall_f),
        .stall_d_o     (stall_d),
        .flush_d_o     (flush_d),
        .flush_e_o     (flush_e)
    );

    // nothing younger than a taken branch or jal reaches execute
    assert property (@(posedge clk_i) disable iff (!rst_n_i)
        redirect_e |=> !(reg_write_e || mem_write_e || branch_e || jump_e));

endmodule

// ==== testbench/tb_core.sv ====
`timescale 1ns/1ps

module tb_core;

    localparam int N_TESTS      = 7;
    localparam int PROG_WORDS   = 16;
    localparam int IMEM_WORDS   = 64;
    localparam int RESET_CYCLES = 10;
    localparam int RUN_CYCLES   = 60;
    // reset edge, full memory load, we drop, release, run, sample
    localparam int TEST_CYCLES     = IMEM_WORDS + RUN_CYCLES + 4;
    localparam int WATCHDOG_CYCLES = RESET_CYCLES + N_TESTS * (TEST_CYCLES + 16) + 100;

    localparam logic [31:0] SELF_JUMP = 32'h0000_006f;  // jal x0,0

    // rv32i opcodes
    localparam int OPC_R  = 7'b0110011;
    localparam int OPC_I  = 7'b0010011;
    localparam int OPC_LW = 7'b0000011;

    logic        clk_i = 1'b0;
    logic        rst_n_i;
    logic        imem_we_i;
    logic [5:0]  imem_addr_i;
    logic [31:0] imem_data_i;
    logic [31:0] a0_o;

    string       test_name [N_TESTS];
    logic [31:0] test_prog [N_TESTS][PROG_WORDS];
    logic [31:0] test_exp  [N_TESTS];
    logic [31:0] pending   [$];  // words of the program being built
    int          n_tests  = 0;
    int          n_checks = 0;
    int          n_errors = 0;
    logic [31:0] lfsr_state = 32'h5269;

    rv_core_top rv_core_top_i (
        .clk_i       (clk_i),
        .rst_n_i     (rst_n_i),
        .imem_we_i   (imem_we_i),
        .imem_addr_i (imem_addr_i),
        .imem_data_i (imem_data_i),
        .a0_o        (a0_o)
    );

    always #5 clk_i = ~clk_i;

    function automatic logic [31:0] enc_r(input int f7, input int f3, input int rd,
                                          input int rs1, input int rs2);
        return {f7[6:0], rs2[4:0], rs1[4:0], f3[2:0], rd[4:0], OPC_R[6:0]};
    endfunction

    function automatic logic [31:0] enc_i(input int op, input int f3, input int rd,
                                          input int rs1, input int imm);
        return {imm[11:0], rs1[4:0], f3[2:0], rd[4:0], op[6:0]};
    endfunction

    function automatic logic [31:0] enc_sw(input int rs2, input int rs1, input int imm);
        return {imm[11:5], rs2[4:0], rs1[4:0], 3'b010, imm[4:0], 7'b0100011};
    endfunction

    function automatic logic [31:0] enc_b(input int f3, input int rs1, input int rs2,
                                          input int imm);
        return {imm[12], imm[10:5], rs2[4:0], rs1[4:0], f3[2:0], imm[4:1], imm[11],
                7'b1100011};
    endfunction

    function automatic logic [31:0] enc_jal(input int rd, input int imm);
        return {imm[20], imm[10:1], imm[11], imm[19:12], rd[4:0], 7'b1101111};
    endfunction

    function automatic logic [31:0] enc_lui(input int rd, input int imm20);
        return {imm20[19:0], rd[4:0], 7'b0110111};
    endfunction

    // x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] galois_lfsr(input logic [31:0] s);
        return (s >> 1) ^ (s[0] ? 32'h8020_0003 : 32'h0);
    endfunction

    task automatic take_bits(input int n, output logic [31:0] v);
        v = '0;
        for (int i = 0; i < n; i++) begin
            v = {v[30:0], lfsr_state[0]};
            lfsr_state = galois_lfsr(lfsr_state);
        end
    endtask

    // turn the pending words into one table entry
    task automatic add_test(input string name, input logic [31:0] exp);
        if (n_tests < N_TESTS) begin
            test_name[n_tests] = name;
            test_exp[n_tests]  = exp;
            for (int i = 0; i < PROG_WORDS; i++) begin
                test_prog[n_tests][i] = (i < pending.size()) ? pending[i] : SELF_JUMP;
            end
        end
        n_tests++;
        pending.delete();
    endtask

    task automatic build_table();
        logic [31:0] r;
        logic [31:0] imm;
        logic [31:0] sum;

        // back-to-back r-type, forwarding from memory and writeback
        pending.push_back(enc_i(OPC_I, 0, 1, 0, 5));
        pending.push_back(enc_i(OPC_I, 0, 2, 0, -3));
        pending.push_back(enc_r(7'h00, 0, 3, 1, 2));     // add  2
        pending.push_back(enc_r(7'h20, 0, 4, 1, 2));     // sub  8
        pending.push_back(enc_r(7'h00, 6, 5, 3, 4));     // or   10
        pending.push_back(enc_r(7'h00, 7, 6, 5, 2));     // and  8
        pending.push_back(enc_r(7'h00, 2, 7, 2, 1));     // slt  -3 < 5
        pending.push_back(enc_lui(8, 20'h12345));
        pending.push_back(enc_r(7'h00, 0, 9, 8, 5));
        pending.push_back(enc_r(7'h00, 0, 9, 9, 6));
        pending.push_back(enc_r(7'h00, 0, 10, 9, 7));
        pending.push_back(SELF_JUMP);
        add_test("alu_chain", 32'h1234_5000 + 32'd10 + 32'd8 + 32'd1);

        pending.push_back(enc_i(OPC_I, 0, 1, 0, -8));
        pending.push_back(enc_i(OPC_I, 2, 2, 1, -7));    // slti gives 1
        pending.push_back(enc_i(OPC_I, 6, 3, 1, 3));     // ori  gives -5
        pending.push_back(enc_i(OPC_I, 7, 4, 3, 12'h07f));
        pending.push_back(enc_r(7'h00, 0, 10, 4, 2));
        pending.push_back(SELF_JUMP);
        add_test("imm_ops", 32'h0000_007b + 32'd1);

        // store data forwarded, then load-use stall
        pending.push_back(enc_i(OPC_I, 0, 1, 0, 12'h123));
        pending.push_back(enc_i(OPC_I, 0, 2, 0, 16));
        pending.push_back(enc_sw(1, 2, 4));
        pending.push_back(enc_i(OPC_LW, 2, 3, 2, 4));
        pending.push_back(enc_r(7'h00, 0, 10, 3, 2));
        pending.push_back(SELF_JUMP);
        add_test("load_use", 32'h123 + 32'd16);

        pending.push_back(enc_i(OPC_I, 0, 10, 0, 1));
        pending.push_back(enc_i(OPC_I, 0, 1, 0, 7));
        pending.push_back(enc_i(OPC_I, 0, 2, 0, 7));
        pending.push_back(enc_b(0, 1, 2, 12));           // beq taken to 24
        pending.push_back(enc_i(OPC_I, 0, 10, 10, 100));
        pending.push_back(enc_i(OPC_I, 0, 10, 10, 200));
        pending.push_back(enc_b(1, 1, 2, 8));            // bne falls through
        pending.push_back(enc_i(OPC_I, 0, 10, 10, 4));
        pending.push_back(SELF_JUMP);
        add_test("branches", 32'd5);

        pending.push_back(enc_i(OPC_I, 0, 1, 0, 3));
        pending.push_back(enc_i(OPC_I, 0, 2, 0, 4));
        pending.push_back(enc_jal(10, 12));              // at address 8
        pending.push_back(enc_i(OPC_I, 0, 10, 0, -1));
        pending.push_back(enc_i(OPC_I, 0, 10, 0, -2));
        pending.push_back(SELF_JUMP);
        add_test("jal_link", 32'd8 + 32'd4);

        // x0 read via memory forward, writeback forward, write-through, storage
        pending.push_back(enc_i(OPC_I, 0, 0, 0, 5));     // x0 must stay zero
        pending.push_back(enc_i(OPC_I, 0, 10, 0, 7));
        pending.push_back(enc_r(7'h00, 0, 10, 10, 0));
        pending.push_back(enc_r(7'h00, 0, 10, 10, 0));
        pending.push_back(enc_r(7'h00, 0, 10, 10, 0));
        pending.push_back(SELF_JUMP);
        add_test("x0_write", 32'd7);

        sum = '0;
        for (int k = 0; k < 3; k++) begin
            take_bits(11, r);
            imm = {{21{r[10]}}, r[10:0]};
            sum = sum + imm;
            pending.push_back(enc_i(OPC_I, 0, 10, (k == 0) ? 0 : 10, imm));
        end
        pending.push_back(SELF_JUMP);
        add_test("random_addi", sum);
    endtask

    task automatic check_value(input string name, input logic [31:0] exp,
                               input logic [31:0] act);
        n_checks++;
        if (act !== exp) begin
            n_errors++;
            $display("[FAIL] %s: expected %h, actual %h", name, exp, act);
        end
    endtask

    // load while held in reset, then let the program run out
    task automatic run_test(input int t);
        @(posedge clk_i);
        rst_n_i <= 1'b0;
        for (int a = 0; a < IMEM_WORDS; a++) begin
            @(posedge clk_i);
            imem_we_i   <= 1'b1;
            imem_addr_i <= 6'(a);
            imem_data_i <= (a < PROG_WORDS) ? test_prog[t][a] : SELF_JUMP;
        end
        @(posedge clk_i);
        imem_we_i <= 1'b0;
        @(posedge clk_i);
        rst_n_i <= 1'b1;
        repeat (RUN_CYCLES) @(posedge clk_i);
        @(negedge clk_i);
        check_value(test_name[t], test_exp[t], a0_o);
    endtask

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clk_i);
        $display("simulation timed out after %0d cycles", WATCHDOG_CYCLES);
        $display("Some tests failed");
        $finish;
    end

    initial begin
        rst_n_i     = 1'b0;
        imem_we_i   = 1'b0;
        imem_addr_i = '0;
        imem_data_i = '0;

        build_table();
        if (n_tests != N_TESTS) begin
            n_errors++;
            $display("test table holds %0d entries instead of %0d", n_tests, N_TESTS);
        end

        repeat (RESET_CYCLES) @(posedge clk_i);
        for (int t = 0; t < N_TESTS; t++) begin
            run_test(t);
        end

        $display("%0d checks, %0d errors", n_checks, n_errors);
        if (n_errors == 0) begin
            $display("All tests passed");
        end else begin
            $display("Some tests failed");
        end
        $finish;
    end

endmodule

// ==== flist.f ====
src/rv_pkg.sv
src/imem.sv
src/reg_file.sv
src/control_decoder.sv
src/alu.sv
src/hazard_unit.sv
src/dmem.sv
src/rv_core_top.sv
testbench/tb_core.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/1ps \
    -f flist.f --top-module tb_core -Mdir obj_dir -o tb_core_sim

output=$(./obj_dir/tb_core_sim || true)
echo "$output"

if grep -q "All tests passed" <<< "$output"; then
    exit 0
fi
exit 1
